// ==== rtl/snn_pkg.sv ====
package snn_pkg;

  ////////////////////////////////////////////////////////////
  // core sizes
  ////////////////////////////////////////////////////////////

  // membrane voltage width
  localparam int WIDTH = 26;
  // spikes per group
  localparam int GROUP_SIZE = 4;
  localparam int NUM_LAYERS = 2;

  // per-layer tables, element 0 is the first layer
  localparam logic [NUM_LAYERS-1:0][4:0] LAYER_INPUTS = {5'd8, 5'd16};
  localparam logic [NUM_LAYERS-1:0][3:0] LAYER_NEURONS = {4'd4, 4'd8};
  localparam logic [NUM_LAYERS-1:0][2:0] LAYER_GROUPS = {
    3'(LAYER_INPUTS[1] / GROUP_SIZE),
    3'(LAYER_INPUTS[0] / GROUP_SIZE)
  };

  // largest layer sizes, set the memory depths
  localparam int MAX_GROUPS = 4;
  localparam int MAX_NEURONS = 8;

  ////////////////////////////////////////////////////////////
  // neuron arithmetic
  ////////////////////////////////////////////////////////////

  // decay factor in units of 1/4096
  localparam logic [NUM_LAYERS-1:0][12:0] VOLTAGE_DECAY = {13'd3672, 13'd3681};
  localparam int DECAY_SHIFT = 12;
  localparam int THRESHOLD = 6;

  // one word per layer, neuron and group
  localparam int WEIGHT_DEPTH = 64;

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  typedef logic [$clog2(NUM_LAYERS)-1:0] layer_t;
  typedef logic [$clog2(MAX_NEURONS)-1:0] neuron_t;
  typedef logic [$clog2(MAX_GROUPS)-1:0] group_addr_t;
  // {layer, neuron, group}
  typedef logic [$clog2(WEIGHT_DEPTH)-1:0] weight_addr_t;
  // bit b is channel 4g+b of group g
  typedef logic [GROUP_SIZE-1:0] spike_group_t;
  typedef logic signed [WIDTH-1:0] voltage_t;

  // raw word from the load port, or four signed 4-bit weights
  // nibble b goes with spike bit b
  typedef union packed {
    logic [GROUP_SIZE*4-1:0]     raw;
    logic [GROUP_SIZE-1:0][3:0]  nibble;
  } weight_word_u;

endpackage

// ==== rtl/snn_if.sv ====
`timescale 1ns/10ps

// one item per cycle from the sequencer into the pipeline
interface neuron_stream_if;
  logic                 valid;
  snn_pkg::layer_t      layer;
  snn_pkg::neuron_t     neuron;
  snn_pkg::group_addr_t group;
  // final item of the current neuron
  logic                 last;
  // neuron with no active group, contributes zero
  logic                 empty;

  modport seq (output valid, layer, neuron, group, last, empty);
  modport spike_rd (input layer, group, empty);
  modport weight_rd (input valid, layer, neuron, group);
  modport lif (input valid, last, empty, neuron, layer);
endinterface

// one pulse per integrated neuron
interface neuron_result_if;
  logic                 valid;
  snn_pkg::layer_t      layer;
  snn_pkg::neuron_t     neuron;
  logic                 spike;
  snn_pkg::voltage_t    voltage;

  modport src (output valid, layer, neuron, spike, voltage);
  modport pack (input valid, layer, neuron, spike);
  modport store (input valid, layer, neuron, voltage);
  modport count (input valid, layer);
endinterface

// ==== rtl/spike_buffer.sv ====
`timescale 1ns/10ps

module spike_buffer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_en,
  input  snn_pkg::spike_group_t i_spike_in,
  neuron_stream_if.spike_rd     stream,
  neuron_result_if.pack         result,
  output snn_pkg::spike_group_t o_spikes,
  output logic                  o_group_wr,
  output snn_pkg::layer_t       o_group_layer,
  output snn_pkg::group_addr_t  o_group_addr,
  output logic                  o_group_active,
  output logic                  o_spike_valid,
  output snn_pkg::spike_group_t o_spike_out
);

  // ping-pong spike memories indexed by the layer that reads them
  snn_pkg::spike_group_t spike_mem [snn_pkg::NUM_LAYERS][snn_pkg::MAX_GROUPS];

  snn_pkg::group_addr_t  in_addr;
  snn_pkg::spike_group_t pack_q;
  snn_pkg::spike_group_t pack_next;
  logic                  pend_wr;
  snn_pkg::layer_t       pend_layer;
  snn_pkg::group_addr_t  pend_addr;
  snn_pkg::spike_group_t wr_data;

  ////////////////////////////////////////////////////////////
  // input group counter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      in_addr <= '0;
    end else if (i_en) begin
      // wraps after the last group of a frame
      if (in_addr == snn_pkg::group_addr_t'(snn_pkg::LAYER_GROUPS[0] - 3'd1)) begin
        in_addr <= '0;
      end else begin
        in_addr <= in_addr + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // result spike packer
  ////////////////////////////////////////////////////////////

  // neuron mod 4 picks the bit
  // bit 0 opens a fresh group
  always_comb begin
    pack_next = (result.neuron[1:0] == 2'd0) ? '0 : pack_q;
    pack_next[result.neuron[1:0]] = result.spike;
  end

  always_ff @(posedge clk) begin
    if (result.valid) begin
      pack_q     <= pack_next;
      pend_layer <= result.layer;
      // neuron / 4
      pend_addr  <= {1'b0, result.neuron[2]};
    end
  end

  // group complete after its fourth neuron
  always_ff @(posedge clk) begin
    if (rst) begin
      pend_wr <= 1'b0;
    end else begin
      pend_wr <= result.valid && (result.neuron[1:0] == 2'd3);
    end
  end

  ////////////////////////////////////////////////////////////
  // group writes
  ////////////////////////////////////////////////////////////

  // first layer results feed the second layer memory
  assign o_group_wr     = i_en || (pend_wr && (pend_layer == 1'b0));
  // input groups go to memory 0 and packed groups to memory 1
  assign o_group_layer  = snn_pkg::layer_t'(!i_en);
  assign o_group_addr   = i_en ? in_addr : pend_addr;
  assign wr_data        = i_en ? i_spike_in : pack_q;
  // active means at least one spike
  assign o_group_active = |wr_data;

  // last layer group leaves the core
  assign o_spike_valid  = pend_wr && (pend_layer == 1'b1);
  assign o_spike_out    = pack_q;

  // registered read with empty items read as no spikes
  always_ff @(posedge clk) begin
    if (o_group_wr) begin
      spike_mem[o_group_layer][o_group_addr] <= wr_data;
    end
    o_spikes <= stream.empty ? '0 : spike_mem[stream.layer][stream.group];
  end

  // new input never collides with packing of first layer results
  a_no_input_during_pack: assert property (@(posedge clk) disable iff (rst)
    !(i_en && result.valid && (result.layer == 1'b0)));

endmodule

// ==== rtl/layer_sequencer.sv ====
`timescale 1ns/10ps

module layer_sequencer (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 i_group_wr,
  input  snn_pkg::layer_t      i_group_layer,
  input  snn_pkg::group_addr_t i_group_addr,
  input  logic                 i_group_active,
  neuron_result_if.count       result,
  neuron_stream_if.seq         stream,
  output logic                 o_valid
);

  // active group addresses per layer
  snn_pkg::group_addr_t stack_mem [snn_pkg::NUM_LAYERS][snn_pkg::MAX_GROUPS];
  logic [$clog2(snn_pkg::MAX_GROUPS+1)-1:0] stack_cnt [snn_pkg::NUM_LAYERS];
  logic [$clog2(snn_pkg::MAX_GROUPS+1)-1:0] cnt_base;

  logic                 start;
  logic                 busy;
  snn_pkg::layer_t      cur_layer;
  snn_pkg::neuron_t     neuron_cnt;
  snn_pkg::neuron_t     last_neuron;
  snn_pkg::group_addr_t ptr;
  logic                 item_empty;
  logic                 item_last;
  snn_pkg::neuron_t     res_cnt;
  snn_pkg::neuron_t     res_last;

  ////////////////////////////////////////////////////////////
  // active group stacks
  ////////////////////////////////////////////////////////////

  // group 0 starts a new frame, so the stack restarts empty
  assign cnt_base = (i_group_addr == '0) ? '0 : stack_cnt[i_group_layer];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int l = 0; l < snn_pkg::NUM_LAYERS; l++) begin
        stack_cnt[l] <= '0;
      end
    end else if (i_group_wr) begin
      stack_cnt[i_group_layer] <= cnt_base + i_group_active;
    end
  end

  // push only groups holding a spike
  always_ff @(posedge clk) begin
    if (i_group_wr && i_group_active) begin
      stack_mem[i_group_layer][cnt_base[1:0]] <= i_group_addr;
    end
  end

  // final group of a layer starts it next cycle
  assign start = i_group_wr &&
    (i_group_addr == snn_pkg::group_addr_t'(snn_pkg::LAYER_GROUPS[i_group_layer] - 3'd1));

  ////////////////////////////////////////////////////////////
  // neuron stream
  ////////////////////////////////////////////////////////////

  assign item_empty  = (stack_cnt[cur_layer] == '0);
  // empty neuron still gets one item
  assign item_last   = item_empty ||
    (ptr == snn_pkg::group_addr_t'(stack_cnt[cur_layer] - 1'b1));
  assign last_neuron = snn_pkg::neuron_t'(snn_pkg::LAYER_NEURONS[cur_layer] - 4'd1);

  assign stream.valid  = busy;
  assign stream.layer  = cur_layer;
  assign stream.neuron = neuron_cnt;
  assign stream.group  = item_empty ? '0 : stack_mem[cur_layer][ptr];
  assign stream.last   = busy && item_last;
  assign stream.empty  = busy && item_empty;

  // layer and neuron counters, ptr walks the stack
  always_ff @(posedge clk) begin
    if (rst) begin
      busy       <= 1'b0;
      cur_layer  <= '0;
      neuron_cnt <= '0;
      ptr        <= '0;
    end else if (start) begin
      busy       <= 1'b1;
      cur_layer  <= i_group_layer;
      neuron_cnt <= '0;
      ptr        <= '0;
    end else if (busy) begin
      if (item_last) begin
        ptr <= '0;
        // neuron counter moves on last
        if (neuron_cnt == last_neuron) begin
          busy       <= 1'b0;
          neuron_cnt <= '0;
        end else begin
          neuron_cnt <= neuron_cnt + 1'b1;
        end
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // integrated neuron count
  ////////////////////////////////////////////////////////////

  assign res_last = snn_pkg::neuron_t'(snn_pkg::LAYER_NEURONS[result.layer] - 4'd1);

  always_ff @(posedge clk) begin
    if (rst) begin
      res_cnt <= '0;
      o_valid <= 1'b0;
    end else begin
      // done one cycle after the last output layer neuron
      o_valid <= result.valid && (res_cnt == res_last) &&
        (result.layer == snn_pkg::layer_t'(snn_pkg::NUM_LAYERS - 1));
      if (result.valid) begin
        res_cnt <= (res_cnt == res_last) ? '0 : res_cnt + 1'b1;
      end
    end
  end

  // a frame never holds more active groups than the stack depth
  a_stack_no_overflow: assert property (@(posedge clk) disable iff (rst)
    (i_group_wr && i_group_active) |-> (cnt_base < snn_pkg::MAX_GROUPS));

endmodule

// ==== rtl/weight_mem.sv ====
`timescale 1ns/10ps

module weight_mem (
  input  logic                  clk,
  input  logic                  i_wr_en,
  input  snn_pkg::weight_addr_t i_wr_addr,
  input  logic [15:0]           i_wr_data,
  neuron_stream_if.weight_rd    stream,
  output snn_pkg::weight_word_u o_weights
);

  snn_pkg::weight_word_u wmem [snn_pkg::WEIGHT_DEPTH];
  snn_pkg::weight_addr_t rd_addr;

  // layer high, then neuron, then group
  assign rd_addr = {stream.layer, stream.neuron, stream.group};

  always_ff @(posedge clk) begin
    // load port writes whole raw words
    if (i_wr_en) begin
      wmem[i_wr_addr].raw <= i_wr_data;
    end
    // one cycle read, lines up with the spike read
    o_weights <= wmem[rd_addr];
  end

  // loading only while the core is idle
  a_no_load_while_streaming: assert property (@(posedge clk)
    !(i_wr_en && stream.valid));

endmodule

// ==== rtl/lif_neuron.sv ====
`timescale 1ns/10ps

module lif_neuron (
  input  logic                  clk,
  input  logic                  rst,
  neuron_stream_if.lif          stream,
  input  snn_pkg::spike_group_t i_spikes,
  input  snn_pkg::weight_word_u i_weights,
  neuron_result_if.src          result
);

  // membrane voltage per layer and neuron
  snn_pkg::voltage_t vmem [snn_pkg::NUM_LAYERS][snn_pkg::MAX_NEURONS];

  logic              valid_d;
  logic              last_d;
  logic              empty_d;
  snn_pkg::layer_t   layer_d;
  snn_pkg::neuron_t  neuron_d;
  snn_pkg::voltage_t acc;
  snn_pkg::voltage_t item_sum;
  snn_pkg::voltage_t total;
  snn_pkg::voltage_t v_old;
  snn_pkg::voltage_t v_decayed;
  snn_pkg::voltage_t v_new;
  logic signed [snn_pkg::WIDTH+13:0] decay_prod;
  logic              fire;

  ////////////////////////////////////////////////////////////
  // stream alignment with memory data
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_d <= 1'b0;
      last_d  <= 1'b0;
    end else begin
      valid_d <= stream.valid;
      last_d  <= stream.last;
    end
  end

  always_ff @(posedge clk) begin
    empty_d  <= stream.empty;
    layer_d  <= stream.layer;
    neuron_d <= stream.neuron;
  end

  ////////////////////////////////////////////////////////////
  // accumulate
  ////////////////////////////////////////////////////////////

  // weights whose spike bit is set
  always_comb begin
    item_sum = '0;
    for (int b = 0; b < snn_pkg::GROUP_SIZE; b++) begin
      if (i_spikes[b] && !empty_d) begin
        item_sum = item_sum + snn_pkg::voltage_t'($signed(i_weights.nibble[b]));
      end
    end
  end

  assign total = acc + item_sum;

  // cleared after each neuron
  always_ff @(posedge clk) begin
    if (rst) begin
      acc <= '0;
    end else if (valid_d) begin
      acc <= last_d ? '0 : total;
    end
  end

  ////////////////////////////////////////////////////////////
  // leaky integrate and fire
  ////////////////////////////////////////////////////////////

  assign v_old = vmem[layer_d][neuron_d];

  always_comb begin
    // full width product, then floor shift
    decay_prod = v_old * $signed({1'b0, snn_pkg::VOLTAGE_DECAY[layer_d]});
    v_decayed  = snn_pkg::voltage_t'(decay_prod >>> snn_pkg::DECAY_SHIFT);
    v_new      = v_decayed + total;
    fire       = (v_new >= snn_pkg::voltage_t'(snn_pkg::THRESHOLD));
  end

  // fired neuron restarts from zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int l = 0; l < snn_pkg::NUM_LAYERS; l++) begin
        for (int n = 0; n < snn_pkg::MAX_NEURONS; n++) begin
          vmem[l][n] <= '0;
        end
      end
    end else if (valid_d && last_d) begin
      vmem[layer_d][neuron_d] <= fire ? '0 : v_new;
    end
  end

  // result two cycles after last
  always_ff @(posedge clk) begin
    if (rst) begin
      result.valid <= 1'b0;
    end else begin
      result.valid <= valid_d && last_d;
    end
  end

  // reported voltage is the stored one
  always_ff @(posedge clk) begin
    result.layer   <= layer_d;
    result.neuron  <= neuron_d;
    result.spike   <= fire;
    result.voltage <= fire ? '0 : v_new;
  end

  // sequencer marks last only on a valid item
  a_last_has_valid: assert property (@(posedge clk) disable iff (rst)
    stream.last |-> stream.valid);

endmodule

// ==== rtl/output_buffer.sv ====
`timescale 1ns/10ps

module output_buffer (
  input  logic              clk,
  neuron_result_if.store    result,
  input  logic              i_rd_en,
  input  logic [1:0]        i_rd_addr,
  output snn_pkg::voltage_t o_rd_data
);

  // one entry per output layer neuron
  snn_pkg::voltage_t obuf [snn_pkg::LAYER_NEURONS[snn_pkg::NUM_LAYERS-1]];

  always_ff @(posedge clk) begin
    // only output layer voltages are kept
    if (result.valid && (result.layer == snn_pkg::layer_t'(snn_pkg::NUM_LAYERS - 1))) begin
      obuf[result.neuron[1:0]] <= result.voltage;
    end
    // registered read port
    if (i_rd_en) begin
      o_rd_data <= obuf[i_rd_addr];
    end
  end

endmodule

// ==== rtl/snn_top.sv ====
`timescale 1ns/10ps

module snn_top (
  input  logic                  clk,
  input  logic                  rst,
  // input spike groups
  input  logic                  i_en,
  input  snn_pkg::spike_group_t i_spike_in,
  // weight load port
  input  logic                  i_weight_wr_en,
  input  snn_pkg::weight_addr_t i_weight_wr_addr,
  input  logic [15:0]           i_weight_wr_data,
  // output buffer read port
  input  logic                  i_obuf_rd_en,
  input  logic [1:0]            i_obuf_addr,
  output snn_pkg::voltage_t     o_obuf_data,
  // inference done and output spikes
  output logic                  o_valid,
  output logic                  o_spike_valid,
  output snn_pkg::spike_group_t o_spike_out
);

  neuron_stream_if stream_if ();
  neuron_result_if result_if ();

  // memory read data into the neuron
  snn_pkg::spike_group_t spikes;
  snn_pkg::weight_word_u weights;

  // group write events toward the stacks
  logic                  group_wr;
  snn_pkg::layer_t       group_layer;
  snn_pkg::group_addr_t  group_addr;
  logic                  group_active;

  spike_buffer spike_buffer0 (
    .clk            (clk),
    .rst            (rst),
    .i_en           (i_en),
    .i_spike_in     (i_spike_in),
    .stream         (stream_if.spike_rd),
    .result         (result_if.pack),
    .o_spikes       (spikes),
    .o_group_wr     (group_wr),
    .o_group_layer  (group_layer),
    .o_group_addr   (group_addr),
    .o_group_active (group_active),
    .o_spike_valid  (o_spike_valid),
    .o_spike_out    (o_spike_out)
  );

  layer_sequencer layer_sequencer0 (
    .clk            (clk),
    .rst            (rst),
    .i_group_wr     (group_wr),
    .i_group_layer  (group_layer),
    .i_group_addr   (group_addr),
    .i_group_active (group_active),
    .result         (result_if.count),
    .stream         (stream_if.seq),
    .o_valid        (o_valid)
  );

  weight_mem weight_mem0 (
    .clk       (clk),
    .i_wr_en   (i_weight_wr_en),
    .i_wr_addr (i_weight_wr_addr),
    .i_wr_data (i_weight_wr_data),
    .stream    (stream_if.weight_rd),
    .o_weights (weights)
  );

  lif_neuron lif_neuron0 (
    .clk       (clk),
    .rst       (rst),
    .stream    (stream_if.lif),
    .i_spikes  (spikes),
    .i_weights (weights),
    .result    (result_if.src)
  );

  output_buffer output_buffer0 (
    .clk       (clk),
    .result    (result_if.store),
    .i_rd_en   (i_obuf_rd_en),
    .i_rd_addr (i_obuf_addr),
    .o_rd_data (o_obuf_data)
  );

endmodule

// ==== bench/tb_snn_top.sv ====
`timescale 1ns/10ps

module tb_snn_top;

  ////////////////////////////////////////////////////////////
  // run constants
  ////////////////////////////////////////////////////////////

  localparam int          CLK_PERIOD     = 10;
  localparam int          RESET_CYCLES   = 5;
  localparam int          NUM_FRAMES     = 4;
  // four groups, four voltages, one spike word
  localparam int          FRAME_WORDS    = 9;
  localparam int          STIM_WORDS     = snn_pkg::WEIGHT_DEPTH + NUM_FRAMES * FRAME_WORDS;
  localparam int          OUT_NEURONS    = 4;
  // bound per frame, strobes plus both layers plus readback
  localparam int          FRAME_CYCLES   = 300;
  localparam int          LOAD_CYCLES    = RESET_CYCLES + snn_pkg::WEIGHT_DEPTH + 2;
  localparam int          TIMEOUT_CYCLES = LOAD_CYCLES + NUM_FRAMES * FRAME_CYCLES;
  localparam string       STIM_FILE      = "bench/snn_input.txt";
  localparam logic [31:0] RAND_SEED      = 32'h6b3f_8a53;

  logic                  clk;
  logic                  rst;
  logic                  i_en;
  snn_pkg::spike_group_t i_spike_in;
  logic                  i_weight_wr_en;
  snn_pkg::weight_addr_t i_weight_wr_addr;
  logic [15:0]           i_weight_wr_data;
  logic                  i_obuf_rd_en;
  logic [1:0]            i_obuf_addr;
  snn_pkg::voltage_t     o_obuf_data;
  logic                  o_valid;
  logic                  o_spike_valid;
  snn_pkg::spike_group_t o_spike_out;

  // weights first, then one record per frame
  logic [31:0] stim [STIM_WORDS];
  int          n_tests;
  int          n_fail;

  snn_top dut0 (
    .clk              (clk),
    .rst              (rst),
    .i_en             (i_en),
    .i_spike_in       (i_spike_in),
    .i_weight_wr_en   (i_weight_wr_en),
    .i_weight_wr_addr (i_weight_wr_addr),
    .i_weight_wr_data (i_weight_wr_data),
    .i_obuf_rd_en     (i_obuf_rd_en),
    .i_obuf_addr      (i_obuf_addr),
    .o_obuf_data      (o_obuf_data),
    .o_valid          (o_valid),
    .o_spike_valid    (o_spike_valid),
    .o_spike_out      (o_spike_out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // hard stop if the core hangs
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_voltage(input string name, input snn_pkg::voltage_t expected,
                               input snn_pkg::voltage_t actual);
    n_tests++;
    if (actual === expected) begin
      $display("PASS %s voltage %0d", name, actual);
    end else begin
      n_fail++;
      $display("FAIL %s expected %0d actual %0d", name, expected, actual);
    end
  endtask

  task automatic check_spikes(input string name, input snn_pkg::spike_group_t expected,
                              input snn_pkg::spike_group_t actual);
    n_tests++;
    if (actual === expected) begin
      $display("PASS %s spikes %h", name, actual);
    end else begin
      n_fail++;
      $display("FAIL %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // events with no value, message says what went wrong
  task automatic check_condition(input string name, input logic ok, input string msg);
    n_tests++;
    if (ok === 1'b1) begin
      $display("PASS %s", name);
    end else begin
      n_fail++;
      $display("%s failed because %s", name, msg);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  // all tasks start and end 1 ns after a rising edge
  task automatic load_weights();
    logic quiet;
    quiet = 1'b1;
    for (int a = 0; a < snn_pkg::WEIGHT_DEPTH; a++) begin
      i_weight_wr_en   = 1'b1;
      i_weight_wr_addr = snn_pkg::weight_addr_t'(a);
      i_weight_wr_data = stim[a][15:0];
      @(posedge clk);
      #1;
      // core must stay idle through the load
      if (o_valid || o_spike_valid) begin
        quiet = 1'b0;
      end
    end
    i_weight_wr_en = 1'b0;
    check_condition("idle_during_load", quiet,
      "o_valid or o_spike_valid pulsed while loading weights");
  endtask

  // readable from the cycle after o_valid, data one cycle after enable
  task automatic read_voltages(input int f, input int base);
    @(posedge clk);
    #1;
    for (int n = 0; n < OUT_NEURONS; n++) begin
      i_obuf_rd_en = 1'b1;
      i_obuf_addr  = 2'(n);
      @(posedge clk);
      #1;
      check_voltage($sformatf("frame%0d_voltage%0d", f, n),
        snn_pkg::voltage_t'(stim[base + 4 + n][snn_pkg::WIDTH-1:0]), o_obuf_data);
    end
    i_obuf_rd_en = 1'b0;
  endtask

  task automatic run_frame(input int f);
    int   base;
    int   waited;
    logic done;
    base = snn_pkg::WEIGHT_DEPTH + f * FRAME_WORDS;
    // one strobe per group, random idle gaps between
    for (int g = 0; g < snn_pkg::MAX_GROUPS; g++) begin
      i_en       = 1'b1;
      i_spike_in = stim[base + g][snn_pkg::GROUP_SIZE-1:0];
      @(posedge clk);
      #1;
      i_en = 1'b0;
      if (g < snn_pkg::MAX_GROUPS - 1) begin
        repeat ($urandom % 3) begin
          @(posedge clk);
          #1;
        end
      end
    end
    // latency depends on active groups
    waited = 0;
    while (!o_valid && waited < FRAME_CYCLES) begin
      @(posedge clk);
      #1;
      waited++;
    end
    done = o_valid;
    check_condition($sformatf("frame%0d_done", f), done,
      $sformatf("o_valid did not arrive within %0d cycles", FRAME_CYCLES));
    if (done) begin
      check_condition($sformatf("frame%0d_spike_valid", f), o_spike_valid,
        "o_spike_valid did not pulse together with o_valid");
      check_spikes($sformatf("frame%0d_spikes", f),
        snn_pkg::spike_group_t'(stim[base + 8][snn_pkg::GROUP_SIZE-1:0]), o_spike_out);
      read_voltages(f, base);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int   fd;
    logic file_ok;
    void'($urandom(RAND_SEED));
    n_tests          = 0;
    n_fail           = 0;
    rst              = 1'b1;
    i_en             = 1'b0;
    i_spike_in       = '0;
    i_weight_wr_en   = 1'b0;
    i_weight_wr_addr = '0;
    i_weight_wr_data = '0;
    i_obuf_rd_en     = 1'b0;
    i_obuf_addr      = '0;
    fd = $fopen(STIM_FILE, "r");
    file_ok = (fd != 0);
    if (file_ok) begin
      $fclose(fd);
      $readmemh(STIM_FILE, stim);
    end else begin
      n_fail++;
      $display("stimulus file %s could not be opened", STIM_FILE);
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    if (file_ok) begin
      load_weights();
      // voltages carry over, frame order matters
      for (int f = 0; f < NUM_FRAMES; f++) begin
        run_frame(f);
      end
    end
    $display("tests run %0d, tests failed %0d", n_tests, n_fail);
    if (n_fail == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== bench/snn_input.txt ====
// weight words in address order, four per line, address is layer*32 + neuron*4 + group
// then per frame the groups 0..3, expected output voltages 0..3 in 26 bits, expected spike word
1111 0000 0000 0000
2222 0000 0000 0000
0000 0043 0000 0000
0000 0000 9000 0000
1111 0000 0000 0201
0000 0000 3000 1111
0000 7777 8000 0000
ffff 0000 0000 0000
0330 0000 0000 0000
0120 0131 0000 0000
0d00 00ce 0000 0000
0440 002f 0000 0000
0000 0000 0000 0000
0000 0000 0000 0000
0000 0000 0000 0000
0000 0000 0000 0000
// all groups active, output neurons 0 and 3 fire
f 3 8 5   0 5 3fffffb 0   9
// no input spikes, decay only
0 0 0 0   0 4 3fffffb 0   0
// groups 1 and 2 skipped, output neuron 1 fires on its history
3 0 0 d   0 0 3fffff7 2   2
// all groups active again
9 1 8 2   3 3 3fffff5 4   0

// ==== sim.f ====
rtl/snn_pkg.sv
rtl/snn_if.sv
rtl/spike_buffer.sv
rtl/layer_sequencer.sv
rtl/weight_mem.sv
rtl/lif_neuron.sv
rtl/output_buffer.sv
rtl/snn_top.sv
bench/tb_snn_top.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -Mdir obj_dir
TOP      = tb_snn_top
FILELIST = sim.f
PASS_MSG = *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir
